//--- source/axil_decoupler_pkg.sv
package axil_decoupler_pkg;

   // AXI-Lite payload widths
   typedef logic [31:0] addr_t;
   typedef logic [31:0] data_t;
   // One strobe per data byte
   typedef logic [3:0]  strb_t;

   // AXI response code
   typedef logic [1:0]  resp_t;

   localparam resp_t RESP_OKAY   = 2'b00;
   localparam resp_t RESP_SLVERR = 2'b10;

   // Decouple status, one bit per channel
   typedef logic [4:0]  status_t;

   // Bit positions inside status_t
   localparam int ST_AW = 0;
   localparam int ST_W  = 1;
   localparam int ST_B  = 2;
   localparam int ST_AR = 3;
   localparam int ST_R  = 4;

endpackage

//--- source/decouple_ctrl.sv
`timescale 1ns/1ps
`default_nettype none

module decouple_ctrl (
   input  wire  aclk,
   input  wire  aresetn,

   // Decouple requests from the outside
   input  wire  decouple,
   input  wire  decouple_force,

   // Idle flags from the two paths
   input  wire  write_idle,
   input  wire  read_idle,

   // Shared control levels
   output logic gate_req,
   output logic isolate,
   output logic force_resp,
   output logic isolated,
   output logic decouple_done
);

   logic isolated_q;
   logic all_idle;

   // Nothing outstanding on either side
   assign all_idle = write_idle & read_idle;

   // Any decouple request, passive or forced
   assign gate_req = decouple | decouple_force;

   // Request side closed once a request shows up or while held isolated
   assign isolate = gate_req | isolated_q;

   // Responses are answered locally when forced or once isolated
   assign force_resp = decouple_force | isolated_q;

   assign isolated = isolated_q;

   // Passive decouple completes only when nothing is in flight
   assign decouple_done = decouple & all_idle;

   // Isolation register
   // Only moves while idle, so no transaction is cut in half
   always_ff @(posedge aclk) begin
      if (!aresetn) begin
         isolated_q <= 1'b0;
      end else if (all_idle) begin
         isolated_q <= gate_req;
      end
   end

   // Peripheral must never be attached or detached with traffic in flight
   a_isolate_only_when_idle : assert property (
      @(posedge aclk) disable iff (!aresetn)
      !(write_idle && read_idle) |=> $stable(isolated_q)
   );

endmodule

`default_nettype wire

//--- source/write_path.sv
`timescale 1ns/1ps
`default_nettype none

module write_path #(
   parameter int outstanding_wreq = 8
) (
   input  wire  aclk,
   input  wire  aresetn,

   // Control levels from decouple_ctrl
   input  wire  gate_req,
   input  wire  isolate,
   input  wire  force_resp,
   input  wire  isolated,

   // Write address channel
   input  axil_decoupler_pkg::addr_t s_awaddr,
   input  wire                       s_awvalid,
   output logic                      s_awready,
   output axil_decoupler_pkg::addr_t m_awaddr,
   output logic                      m_awvalid,
   input  wire                       m_awready,

   // Write data channel
   input  axil_decoupler_pkg::data_t s_wdata,
   input  axil_decoupler_pkg::strb_t s_wstrb,
   input  wire                       s_wvalid,
   output logic                      s_wready,
   output axil_decoupler_pkg::data_t m_wdata,
   output axil_decoupler_pkg::strb_t m_wstrb,
   output logic                      m_wvalid,
   input  wire                       m_wready,

   // Write response channel
   output axil_decoupler_pkg::resp_t s_bresp,
   output logic                      s_bvalid,
   input  wire                       s_bready,
   input  axil_decoupler_pkg::resp_t m_bresp,
   input  wire                       m_bvalid,
   output logic                      m_bready,

   // Back to the controller and status
   output logic                      write_idle,
   output logic [2:0]                wstatus
);

   localparam int cnt_w = $clog2(outstanding_wreq + 1);

   typedef logic [cnt_w-1:0] wcount_t;

   localparam wcount_t wlimit = wcount_t'(outstanding_wreq);

   // Responses owed to the master, and data beats still owed by it
   wcount_t outst_wresp;
   wcount_t outst_wdata;

   logic aw_hs;
   logic w_hs;
   logic b_hs;
   logic no_wresp;
   logic no_wdata;
   logic aw_full;
   logic b_expected;
   logic w_bp;
   logic w_gate;
   logic safe_b;
   logic aw_dec;
   logic w_dec;

   // Handshakes seen by the master
   assign aw_hs = s_awvalid & s_awready;
   assign w_hs  = s_wvalid & s_wready;
   assign b_hs  = s_bvalid & s_bready;

   assign no_wresp = (outst_wresp == '0);
   assign no_wdata = (outst_wdata == '0);
   assign aw_full  = (outst_wresp >= wlimit);

   // An address whose data is complete still waits for its B
   assign b_expected = (outst_wresp != outst_wdata);

   // AW channel
   // Limit has priority, so even swallowed requests stay counted
   assign m_awvalid = s_awvalid & ~(aw_full | gate_req | isolated);
   assign m_awaddr  = s_awaddr;

   always_comb begin
      if (aw_full) begin
         s_awready = 1'b0;
      end else if (isolated) begin
         s_awready = 1'b1;
      end else if (gate_req) begin
         s_awready = 1'b0;
      end else begin
         s_awready = m_awready;
      end
   end

   // W channel
   // Beats owed always get through, otherwise W would hang its AW
   // Beat count is bounded by the AW count, so back-pressure only
   // holds a W that has no accepted address yet
   assign w_bp   = aw_full & no_wdata;
   assign w_gate = gate_req & no_wdata;

   assign m_wvalid = s_wvalid & ~(w_bp | w_gate | isolated);
   assign m_wdata  = s_wdata;
   assign m_wstrb  = s_wstrb;

   always_comb begin
      if (w_bp) begin
         s_wready = 1'b0;
      end else if (isolated) begin
         s_wready = 1'b1;
      end else if (w_gate) begin
         s_wready = 1'b0;
      end else begin
         s_wready = m_wready;
      end
   end

   // B channel
   // Quiet only when decoupling and no response is owed
   assign safe_b = isolate & ~b_expected;

   always_comb begin
      if (safe_b) begin
         s_bvalid = 1'b0;
         s_bresp  = m_bresp;
         m_bready = 1'b0;
      end else if (force_resp) begin
         // Local SLVERR, peripheral left untouched
         s_bvalid = 1'b1;
         s_bresp  = axil_decoupler_pkg::RESP_SLVERR;
         m_bready = 1'b0;
      end else begin
         s_bvalid = m_bvalid;
         s_bresp  = m_bresp;
         m_bready = s_bready;
      end
   end

   // Response counter
   always_ff @(posedge aclk) begin
      if (!aresetn) begin
         outst_wresp <= '0;
      end else begin
         case ({aw_hs, b_hs})
            2'b10:   outst_wresp <= outst_wresp + wcount_t'(1);
            2'b01:   outst_wresp <= outst_wresp - wcount_t'(1);
            default: outst_wresp <= outst_wresp;
         endcase
      end
   end

   // Beat counter, AW always leads its W
   always_ff @(posedge aclk) begin
      if (!aresetn) begin
         outst_wdata <= '0;
      end else begin
         case ({aw_hs, w_hs})
            2'b10:   outst_wdata <= outst_wdata + wcount_t'(1);
            2'b01:   outst_wdata <= outst_wdata - wcount_t'(1);
            default: outst_wdata <= outst_wdata;
         endcase
      end
   end

   assign write_idle = no_wresp & no_wdata;

   // Status bits
   assign aw_dec = gate_req;
   assign w_dec  = gate_req & no_wdata;

   assign wstatus[0] = aw_dec;
   assign wstatus[1] = w_dec;
   assign wstatus[2] = safe_b & aw_dec & w_dec;

   // Counters stay inside the limit
   a_wcount_limit : assert property (
      @(posedge aclk) disable iff (!aresetn)
      (outst_wresp <= wlimit) && (outst_wdata <= wlimit)
   );

   // No B from the peripheral or a W from the master without an address
   a_wcount_no_underflow : assert property (
      @(posedge aclk) disable iff (!aresetn)
      (b_hs |-> !no_wresp) and (w_hs && no_wdata |-> aw_hs)
   );

endmodule

`default_nettype wire

//--- source/read_path.sv
`timescale 1ns/1ps
`default_nettype none

module read_path #(
   parameter int outstanding_rreq = 8
) (
   input  wire  aclk,
   input  wire  aresetn,

   // Control levels from decouple_ctrl
   input  wire  gate_req,
   input  wire  isolate,
   input  wire  force_resp,
   input  wire  isolated,

   // Read address channel
   input  axil_decoupler_pkg::addr_t s_araddr,
   input  wire                       s_arvalid,
   output logic                      s_arready,
   output axil_decoupler_pkg::addr_t m_araddr,
   output logic                      m_arvalid,
   input  wire                       m_arready,

   // Read data channel
   output axil_decoupler_pkg::data_t s_rdata,
   output axil_decoupler_pkg::resp_t s_rresp,
   output logic                      s_rvalid,
   input  wire                       s_rready,
   input  axil_decoupler_pkg::data_t m_rdata,
   input  axil_decoupler_pkg::resp_t m_rresp,
   input  wire                       m_rvalid,
   output logic                      m_rready,

   // Back to the controller and status
   output logic                      read_idle,
   output logic [1:0]                rstatus
);

   localparam int cnt_w = $clog2(outstanding_rreq + 1);

   typedef logic [cnt_w-1:0] rcount_t;

   localparam rcount_t rlimit = rcount_t'(outstanding_rreq);

   // Reads accepted but not yet answered
   rcount_t outst_rresp;

   logic ar_hs;
   logic r_hs;
   logic no_rresp;
   logic ar_full;
   logic safe_r;

   assign ar_hs = s_arvalid & s_arready;
   assign r_hs  = s_rvalid & s_rready;

   assign no_rresp = (outst_rresp == '0);
   assign ar_full  = (outst_rresp >= rlimit);

   // AR channel
   assign m_arvalid = s_arvalid & ~(ar_full | gate_req | isolated);
   assign m_araddr  = s_araddr;

   always_comb begin
      if (ar_full) begin
         s_arready = 1'b0;
      end else if (isolated) begin
         // Swallowed, answered later with SLVERR
         s_arready = 1'b1;
      end else if (gate_req) begin
         s_arready = 1'b0;
      end else begin
         s_arready = m_arready;
      end
   end

   // R channel
   // Data is don't-care on a forced response
   assign s_rdata = m_rdata;
   assign safe_r  = isolate & no_rresp;

   always_comb begin
      if (safe_r) begin
         s_rvalid = 1'b0;
         s_rresp  = m_rresp;
         m_rready = 1'b0;
      end else if (force_resp) begin
         s_rvalid = 1'b1;
         s_rresp  = axil_decoupler_pkg::RESP_SLVERR;
         m_rready = 1'b0;
      end else begin
         s_rvalid = m_rvalid;
         s_rresp  = m_rresp;
         m_rready = s_rready;
      end
   end

   // Outstanding read counter
   always_ff @(posedge aclk) begin
      if (!aresetn) begin
         outst_rresp <= '0;
      end else begin
         case ({ar_hs, r_hs})
            2'b10:   outst_rresp <= outst_rresp + rcount_t'(1);
            2'b01:   outst_rresp <= outst_rresp - rcount_t'(1);
            default: outst_rresp <= outst_rresp;
         endcase
      end
   end

   assign read_idle = no_rresp;

   // AR then R status
   assign rstatus[0] = gate_req;
   assign rstatus[1] = safe_r;

   // Count stays inside the limit
   a_rcount_limit : assert property (
      @(posedge aclk) disable iff (!aresetn)
      outst_rresp <= rlimit
   );

endmodule

`default_nettype wire

//--- source/axil_decoupler_top.sv
`timescale 1ns/1ps
`default_nettype none

module axil_decoupler_top #(
   parameter int outstanding_wreq = 8,
   parameter int outstanding_rreq = 8
) (
   input  wire                         aclk,
   input  wire                         aresetn,

   // Master facing side
   input  axil_decoupler_pkg::addr_t   s_awaddr,
   input  wire                         s_awvalid,
   output logic                        s_awready,
   input  axil_decoupler_pkg::data_t   s_wdata,
   input  axil_decoupler_pkg::strb_t   s_wstrb,
   input  wire                         s_wvalid,
   output logic                        s_wready,
   output axil_decoupler_pkg::resp_t   s_bresp,
   output logic                        s_bvalid,
   input  wire                         s_bready,
   input  axil_decoupler_pkg::addr_t   s_araddr,
   input  wire                         s_arvalid,
   output logic                        s_arready,
   output axil_decoupler_pkg::data_t   s_rdata,
   output axil_decoupler_pkg::resp_t   s_rresp,
   output logic                        s_rvalid,
   input  wire                         s_rready,

   // Peripheral facing side
   output axil_decoupler_pkg::addr_t   m_awaddr,
   output logic                        m_awvalid,
   input  wire                         m_awready,
   output axil_decoupler_pkg::data_t   m_wdata,
   output axil_decoupler_pkg::strb_t   m_wstrb,
   output logic                        m_wvalid,
   input  wire                         m_wready,
   input  axil_decoupler_pkg::resp_t   m_bresp,
   input  wire                         m_bvalid,
   output logic                        m_bready,
   output axil_decoupler_pkg::addr_t   m_araddr,
   output logic                        m_arvalid,
   input  wire                         m_arready,
   input  axil_decoupler_pkg::data_t   m_rdata,
   input  axil_decoupler_pkg::resp_t   m_rresp,
   input  wire                         m_rvalid,
   output logic                        m_rready,

   // Decouple control
   input  wire                         decouple,
   input  wire                         decouple_force,
   output logic                        decouple_done,
   output axil_decoupler_pkg::status_t status
);

   logic       gate_req;
   logic       isolate;
   logic       force_resp;
   logic       isolated;
   logic       write_idle;
   logic       read_idle;
   logic [2:0] wstatus;
   logic [1:0] rstatus;

   // Isolation register and shared levels
   decouple_ctrl decouple_ctrl_i (
      .aclk           (aclk),
      .aresetn        (aresetn),
      .decouple       (decouple),
      .decouple_force (decouple_force),
      .write_idle     (write_idle),
      .read_idle      (read_idle),
      .gate_req       (gate_req),
      .isolate        (isolate),
      .force_resp     (force_resp),
      .isolated       (isolated),
      .decouple_done  (decouple_done)
   );

   // AW, W and B
   write_path #(
      .outstanding_wreq (outstanding_wreq)
   ) write_path_i (
      .aclk       (aclk),
      .aresetn    (aresetn),
      .gate_req   (gate_req),
      .isolate    (isolate),
      .force_resp (force_resp),
      .isolated   (isolated),
      .s_awaddr   (s_awaddr),
      .s_awvalid  (s_awvalid),
      .s_awready  (s_awready),
      .m_awaddr   (m_awaddr),
      .m_awvalid  (m_awvalid),
      .m_awready  (m_awready),
      .s_wdata    (s_wdata),
      .s_wstrb    (s_wstrb),
      .s_wvalid   (s_wvalid),
      .s_wready   (s_wready),
      .m_wdata    (m_wdata),
      .m_wstrb    (m_wstrb),
      .m_wvalid   (m_wvalid),
      .m_wready   (m_wready),
      .s_bresp    (s_bresp),
      .s_bvalid   (s_bvalid),
      .s_bready   (s_bready),
      .m_bresp    (m_bresp),
      .m_bvalid   (m_bvalid),
      .m_bready   (m_bready),
      .write_idle (write_idle),
      .wstatus    (wstatus)
   );

   // AR and R
   read_path #(
      .outstanding_rreq (outstanding_rreq)
   ) read_path_i (
      .aclk       (aclk),
      .aresetn    (aresetn),
      .gate_req   (gate_req),
      .isolate    (isolate),
      .force_resp (force_resp),
      .isolated   (isolated),
      .s_araddr   (s_araddr),
      .s_arvalid  (s_arvalid),
      .s_arready  (s_arready),
      .m_araddr   (m_araddr),
      .m_arvalid  (m_arvalid),
      .m_arready  (m_arready),
      .s_rdata    (s_rdata),
      .s_rresp    (s_rresp),
      .s_rvalid   (s_rvalid),
      .s_rready   (s_rready),
      .m_rdata    (m_rdata),
      .m_rresp    (m_rresp),
      .m_rvalid   (m_rvalid),
      .m_rready   (m_rready),
      .read_idle  (read_idle),
      .rstatus    (rstatus)
   );

   // Status vector in channel order
   assign status[axil_decoupler_pkg::ST_AW] = wstatus[0];
   assign status[axil_decoupler_pkg::ST_W]  = wstatus[1];
   assign status[axil_decoupler_pkg::ST_B]  = wstatus[2];
   assign status[axil_decoupler_pkg::ST_AR] = rstatus[0];
   assign status[axil_decoupler_pkg::ST_R]  = rstatus[1];

endmodule

`default_nettype wire

//--- test/tb_vectors.svh
// Columns: op, addr, random data, decouple, decouple_force, peripheral stall,
// blocked AW expected, expected resp, check read data, expected status, expected done

localparam int n_rows = 17;

task automatic fill_table;
   // Pass-through write then read back
   set_row(0,  op_wr,  32'h04, 1, 0, 0, 0, 0, 2'b00, 0, 5'h00, 0);
   set_row(1,  op_rd,  32'h04, 0, 0, 0, 0, 0, 2'b00, 1, 5'h00, 0);
   // Passive decouple while idle, requests swallowed with SLVERR
   set_row(2,  op_chk, 32'h00, 0, 1, 0, 0, 0, 2'b00, 0, 5'h1f, 1);
   set_row(3,  op_wr,  32'h08, 1, 1, 0, 0, 0, 2'b10, 0, 5'h1f, 1);
   set_row(4,  op_rd,  32'h08, 0, 1, 0, 0, 0, 2'b10, 0, 5'h1f, 1);
   set_row(5,  op_chk, 32'h00, 0, 0, 0, 0, 0, 2'b00, 0, 5'h00, 0);
   // Read left hanging in the peripheral, then forced off
   set_row(6,  op_rd,  32'h04, 0, 0, 0, 1, 0, 2'b00, 0, 5'h00, 0);
   set_row(7,  op_frc, 32'h00, 0, 0, 1, 0, 0, 2'b10, 0, 5'h1f, 0);
   set_row(8,  op_chk, 32'h00, 0, 0, 0, 0, 0, 2'b00, 0, 5'h00, 0);
   // Two writes fill the limit, the third waits for B
   set_row(9,  op_wr,  32'h0c, 1, 0, 0, 1, 0, 2'b00, 0, 5'h00, 0);
   set_row(10, op_wr,  32'h10, 1, 0, 0, 1, 0, 2'b00, 0, 5'h00, 0);
   set_row(11, op_wr,  32'h14, 1, 0, 0, 0, 1, 2'b00, 0, 5'h00, 0);
   set_row(12, op_rd,  32'h10, 0, 0, 0, 0, 0, 2'b00, 1, 5'h00, 0);
   // Decouple and release, then normal traffic again
   set_row(13, op_chk, 32'h00, 0, 1, 0, 0, 0, 2'b00, 0, 5'h1f, 1);
   set_row(14, op_chk, 32'h00, 0, 0, 0, 0, 0, 2'b00, 0, 5'h00, 0);
   set_row(15, op_wr,  32'h1c, 1, 0, 0, 0, 0, 2'b00, 0, 5'h00, 0);
   set_row(16, op_rd,  32'h1c, 0, 0, 0, 0, 0, 2'b00, 1, 5'h00, 0);
endtask

//--- test/tb_axil_decoupler.sv
`timescale 1ns/1ps

module tb_axil_decoupler;

   localparam int wreq_limit = 2;
   localparam logic [1:0] op_wr = 2'd0;
   localparam logic [1:0] op_rd = 2'd1;
   localparam logic [1:0] op_frc = 2'd2;
   localparam logic [1:0] op_chk = 2'd3;

   logic aclk = 1'b0;
   logic aresetn = 1'b0;
   logic [31:0] s_awaddr = '0, s_wdata = '0, s_araddr = '0;
   logic s_awvalid = 1'b0, s_wvalid = 1'b0, s_arvalid = 1'b0;
   logic [3:0] s_wstrb = 4'hf;
   logic s_bready = 1'b1, s_rready = 1'b1;
   logic s_awready, s_wready, s_bvalid, s_arready, s_rvalid;
   logic [1:0] s_bresp, s_rresp;
   logic [31:0] s_rdata, m_awaddr, m_wdata, m_araddr;
   logic [3:0] m_wstrb;
   logic m_awvalid, m_wvalid, m_bready, m_arvalid, m_rready;
   logic m_awready = 1'b1, m_wready = 1'b1, m_arready = 1'b1;
   logic m_bvalid = 1'b0, m_rvalid = 1'b0;
   logic [1:0] m_bresp = 2'b00, m_rresp = 2'b00;
   logic [31:0] m_rdata = '0;
   logic decouple = 1'b0, decouple_force = 1'b0;
   logic decouple_done;
   logic [4:0] status;

   // Table columns
   logic [1:0] t_op [32];
   logic [31:0] t_addr [32];
   logic t_rnd [32], t_dec [32], t_frc [32], t_stall [32], t_blk [32], t_chk [32];
   logic [1:0] t_resp [32];
   logic [4:0] t_status [32];
   logic t_done [32];

   // Peripheral model state
   logic [31:0] mem [16];
   logic [31:0] aw_q [$], w_q [$], rd_pend [$];
   logic [31:0] wr_addr;
   int pend_b = 0;
   logic hold_b = 1'b0, hold_r = 1'b0;
   int flush_req = 0, flush_done = 0;

   // Master side bookkeeping kept by the monitor
   int aw_cnt = 0, w_cnt = 0, ar_cnt = 0, m_req_cnt = 0, bad_rready = 0;
   logic [1:0] b_q [$], r_q [$];
   logic [31:0] rdata_q [$];
   logic awready_snap = 1'b0, m_awvalid_snap = 1'b0, done_snap = 1'b0;
   logic [4:0] status_snap = '0;

   logic [31:0] shadow [16];
   integer seed = 32'h413d;
   int err_cnt = 0, cyc = 0, wr_n = 0, rd_n = 0;

   axil_decoupler_top #(
      .outstanding_wreq (wreq_limit),
      .outstanding_rreq (8)
   ) axil_decoupler_top_i (.*);

   initial begin
      forever #5 aclk = ~aclk;
   end

   task automatic set_row(input int i, input logic [1:0] op, input logic [31:0] addr,
                          input logic rnd, dec, frc, stall, blk, input logic [1:0] resp,
                          input logic chk, input logic [4:0] st, input logic done);
      t_op[i] = op;
      t_addr[i] = addr;
      t_rnd[i] = rnd;
      t_dec[i] = dec;
      t_frc[i] = frc;
      t_stall[i] = stall;
      t_blk[i] = blk;
      t_resp[i] = resp;
      t_chk[i] = chk;
      t_status[i] = st;
      t_done[i] = done;
   endtask

   `include "tb_vectors.svh"

   task automatic check_val(input logic [31:0] got, input logic [31:0] exp, input string what);
      if (got !== exp) begin
         $display("ERROR %0t: %s got %h expected %h", $time, what, got, exp);
         err_cnt++;
      end
   endtask

   // Peripheral drives on the falling edge
   // Handshakes sampled just before the rising edge
   always @(negedge aclk) begin
      m_bvalid = (pend_b > 0) && !hold_b;
      m_rvalid = (rd_pend.size() > 0) && !hold_r;
      m_rdata = (rd_pend.size() > 0) ? rd_pend[0] : '0;
      #4;
      if (aresetn) begin
         awready_snap = s_awready;
         m_awvalid_snap = m_awvalid;
         status_snap = status;
         done_snap = decouple_done;
         if (s_awvalid && s_awready) aw_cnt++;
         if (s_wvalid && s_wready) w_cnt++;
         if (s_arvalid && s_arready) ar_cnt++;
         if (s_bvalid && s_bready) b_q.push_back(s_bresp);
         if (s_rvalid && s_rready) begin
            r_q.push_back(s_rresp);
            rdata_q.push_back(s_rdata);
            // Forced R must not pull from the peripheral
            if (decouple_force && m_rready) bad_rready++;
         end
         if (m_awvalid || m_arvalid) m_req_cnt++;
         if (m_awvalid && m_awready) aw_q.push_back(m_awaddr);
         if (m_wvalid && m_wready) begin
            w_q.push_back(m_wdata);
            // Strobes reach the peripheral as the master sent them
            check_val(32'(m_wstrb), 32'(s_wstrb), "m_wstrb");
         end
         while (aw_q.size() > 0 && w_q.size() > 0) begin
            wr_addr = aw_q.pop_front();
            mem[wr_addr[5:2]] = w_q.pop_front();
            pend_b++;
         end
         if (m_bvalid && m_bready) pend_b--;
         if (m_rvalid && m_rready) void'(rd_pend.pop_front());
         if (m_arvalid && m_arready) rd_pend.push_back(mem[m_araddr[5:2]]);
         // Peripheral drops a read it never answered
         if (flush_req != flush_done) begin
            rd_pend.delete();
            flush_done = flush_req;
         end
      end
   end

   always @(posedge aclk) begin
      cyc++;
      if (cyc > n_rows * 50 + 100) begin
         $display("timeout: run exceeded %0d cycles", n_rows * 50 + 100);
         $display("sim failed");
         $finish;
      end
   end

   task automatic do_write(input logic [31:0] addr, input logic [31:0] data, input logic blk);
      int aw0;
      int w0;
      aw0 = aw_cnt;
      w0 = w_cnt;
      s_awaddr = addr;
      s_wdata = data;
      s_awvalid = 1'b1;
      s_wvalid = 1'b1;
      if (blk) begin
         repeat (3) @(negedge aclk);
         check_val(32'(awready_snap), 0, "s_awready at limit");
         check_val(32'(m_awvalid_snap), 0, "m_awvalid at limit");
         hold_b <= 1'b0;
      end
      while (s_awvalid || s_wvalid) begin
         @(negedge aclk);
         if (aw_cnt != aw0) s_awvalid = 1'b0;
         if (w_cnt != w0) s_wvalid = 1'b0;
      end
   endtask

   task automatic do_read(input logic [31:0] addr);
      int ar0;
      ar0 = ar_cnt;
      s_araddr = addr;
      s_arvalid = 1'b1;
      while (ar_cnt == ar0) @(negedge aclk);
      s_arvalid = 1'b0;
   endtask

   task automatic run_row(input int i);
      logic [31:0] data;
      int req0;
      int err0;
      err0 = err_cnt;
      @(negedge aclk);
      decouple = t_dec[i];
      decouple_force = t_frc[i];
      req0 = m_req_cnt;
      if (t_stall[i] && t_op[i] == op_wr) hold_b <= 1'b1;
      if (t_stall[i] && t_op[i] == op_rd) hold_r <= 1'b1;
      if (!t_stall[i] && !t_blk[i]) begin
         hold_b <= 1'b0;
         hold_r <= 1'b0;
      end
      data = t_rnd[i] ? $random(seed) : 32'h0;
      case (t_op[i])
         op_wr: begin
            do_write(t_addr[i], data, t_blk[i]);
            if (t_resp[i] == axil_decoupler_pkg::RESP_OKAY) shadow[t_addr[i][5:2]] = data;
            if (!t_stall[i]) begin
               while (b_q.size() <= wr_n) @(negedge aclk);
               check_val(32'(b_q[wr_n]), 32'(t_resp[i]), "bresp");
            end
            wr_n++;
         end
         op_rd: begin
            do_read(t_addr[i]);
            if (!t_stall[i]) begin
               while (r_q.size() <= rd_n) @(negedge aclk);
               check_val(32'(r_q[rd_n]), 32'(t_resp[i]), "rresp");
               if (t_chk[i]) check_val(rdata_q[rd_n], shadow[t_addr[i][5:2]], "rdata");
            end
            rd_n++;
         end
         op_frc: begin
            while (r_q.size() < rd_n) @(negedge aclk);
            check_val(32'(r_q[rd_n-1]), 32'(t_resp[i]), "forced rresp");
            flush_req++;
         end
         default: ;
      endcase
      // Give the isolation register time to follow
      repeat (2) @(negedge aclk);
      check_val(32'(status_snap), 32'(t_status[i]), "status");
      check_val(32'(done_snap), 32'(t_done[i]), "decouple_done");
      check_val(32'(bad_rready), 0, "m_rready during forced R");
      if ((t_dec[i] || t_frc[i]) && t_op[i] != op_chk)
         check_val(32'(m_req_cnt - req0), 0, "m_awvalid/m_arvalid while decoupled");
      $display("row %0d: %s", i, (err_cnt == err0) ? "ok" : "failed");
   endtask

   initial begin
      for (int a = 0; a < 16; a++) begin
         mem[a] = 32'h0;
         shadow[a] = 32'h0;
      end
      fill_table();
      repeat (3) @(negedge aclk);
      aresetn = 1'b1;
      for (int i = 0; i < n_rows; i++) begin
         run_row(i);
      end
      $display("rows run: %0d, errors: %0d", n_rows, err_cnt);
      if (err_cnt == 0) begin
         $display("sim passed");
      end else begin
         $display("sim failed");
      end
      $finish;
   end

endmodule

//--- verilog.f
+incdir+test
source/axil_decoupler_pkg.sv
source/decouple_ctrl.sv
source/write_path.sv
source/read_path.sv
source/axil_decoupler_top.sv
test/tb_axil_decoupler.sv

//--- run_sim.sh
#!/usr/bin/env bash
set -u

cd "$(dirname "$0")" || exit 1

verilator --binary --timing --assert -f verilog.f \
   --top-module tb_axil_decoupler -Mdir obj_dir -o sim_tb > build.log 2>&1
if [ $? -ne 0 ]; then
   echo "build failed, see build.log"
   exit 1
fi

./obj_dir/sim_tb > sim.log 2>&1
if [ $? -ne 0 ]; then
   echo "simulation exited with an error, see sim.log"
   exit 1
fi

if grep -q "sim failed" sim.log; then
   echo "simulation reported failure, see sim.log"
   exit 1
fi

echo "simulation finished without failure"
exit 0
